// ==== Bender.yml ====
package:
  name: snowball_cache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/dual_port_ram.sv
      - source/mem_port_fsm.sv
      - source/snowball_cache.sv
      - source/snowball_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/mem_model.sv
      - tests/snowball_tb.sv

// ==== source/cache_pkg.sv ====
// shared types of the snowball cache, imported by every RTL module of the design
package cache_pkg;

  `include "cache_settings.svh"

  typedef logic [`WORD_BITS-1:0]      word_t;
  typedef logic [`ADDR_BITS-1:0]      addr_t;       // page, tlb index, line index
  typedef logic [`PAGE_BITS-1:0]      page_t;
  typedef logic [`TLB_IDX_BITS-1:0]   tlb_idx_t;
  typedef logic [`CACHE_IDX_BITS-1:0] line_idx_t;
  typedef logic [`CACHE_TAG_BITS-1:0] cache_tag_t;  // physical page then tlb index

  typedef struct packed {
    page_t ppage;
    page_t vtag;
  } tlb_entry_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  write;
    logic  tlb_load;  // wdata carries a tlb_entry_t
    logic  inhibit;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;
    logic  fault;
  } cpu_rsp_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  write;
  } mem_cmd_t;

  typedef struct packed {
    addr_t base;    // block base, or the word itself when single
    word_t wdata;
    logic  write;
    logic  single;
  } mem_job_t;

  typedef struct packed {
    logic      we;
    line_idx_t idx;
    word_t     data;
  } refill_word_t;

  typedef struct packed {
    refill_word_t [`BLOCK_WORDS-1:0] word;
  } mem_done_t;

  typedef enum logic [2:0] {IDLE, LOOKUP, DECIDE, WAIT_MEM, ACK, RELEASE} cache_state_t;
  typedef enum logic [2:0] {M_IDLE, M_REQ, M_WAIT_LOW, M_NEXT, M_DONE} mem_state_t;

endpackage

// ==== source/cache_settings.svh ====
// width and depth macros for the snowball cache, included by cache_pkg and the RTL files
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// --------------------------------------------------
// address split
// --------------------------------------------------
`define CACHE_IDX_BITS 8   // line index, addr[7:0]
`define TLB_IDX_BITS   8   // translation index, addr[15:8]
`define PAGE_BITS      16  // virtual or physical page

`define ADDR_BITS      (`PAGE_BITS + `TLB_IDX_BITS + `CACHE_IDX_BITS)
`define CACHE_TAG_BITS (`PAGE_BITS + `TLB_IDX_BITS)

// --------------------------------------------------
// data and array sizes
// --------------------------------------------------
`define WORD_BITS      32
`define BLOCK_WORDS    2   // words per refill

`define CACHE_LINES    (1 << `CACHE_IDX_BITS)
`define TLB_ENTRIES    (1 << `TLB_IDX_BITS)

`endif

// ==== source/dual_port_ram.sv ====
// registered-read RAM with one write and one read port, used for the cache data, tag and tlb
`timescale 1ns/1ns

module dual_port_ram
#(
  parameter int WIDTH = 32,
  parameter int DEPTH = 256
)
(
  input  logic                     CPU_CLK,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic [WIDTH-1:0]         wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output logic [WIDTH-1:0]         rdata
);

  logic [WIDTH-1:0] mem [DEPTH];

  // same address written and read gives the old word, as in block RAM
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

// ==== source/mem_port_fsm.sv ====
// memory master of the snowball cache, turns controller jobs into four-phase word transfers
`timescale 1ns/1ns
`include "cache_settings.svh"

module mem_port_fsm import cache_pkg::*;
(
  input  logic      CPU_CLK,
  input  logic      RST,
  input  logic      job_req,
  input  mem_job_t  job,
  output logic      job_ack,
  output mem_done_t done,
  output logic      mem_req,
  output mem_cmd_t  mem_cmd,
  input  logic      mem_ack,
  input  word_t     mem_rdata
);

  mem_state_t               state;
  mem_job_t                 job_q;
  logic                     cnt;        // word within the block
  logic [`BLOCK_WORDS-1:0]  done_we;
  word_t [`BLOCK_WORDS-1:0] done_data;
  logic                     last_word;

  assign last_word = job_q.write || job_q.single || (cnt == 1'(`BLOCK_WORDS - 1));

  // --------------------------------------------------
  // job and word handshakes
  // --------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state   <= M_IDLE;
      mem_req <= 1'b0;
      job_ack <= 1'b0;
      cnt     <= 1'b0;
      done_we <= '0;
    end
    else
    begin
      case (state)
        M_IDLE:
          if (job_req)
          begin
            cnt     <= 1'b0;
            done_we <= '0;          // stale refill strobes off
            mem_req <= 1'b1;
            state   <= M_REQ;
          end
        M_REQ:
          if (mem_ack)
          begin
            done_we[cnt] <= !job_q.write && !job_q.single;
            mem_req      <= 1'b0;
            state        <= M_WAIT_LOW;
          end
        M_WAIT_LOW:
          if (!mem_ack)
          begin
            if (last_word)
            begin
              job_ack <= 1'b1;
              state   <= M_DONE;
            end
            else
            begin
              state <= M_NEXT;
            end
          end
        M_NEXT:
        begin
          cnt     <= cnt + 1'b1;
          mem_req <= 1'b1;
          state   <= M_REQ;
        end
        M_DONE:
          if (!job_req)
          begin
            job_ack <= 1'b0;
            state   <= M_IDLE;
          end
        default:
          state <= M_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // command and read data
  // --------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (state == M_IDLE && job_req)
    begin
      job_q   <= job;
      mem_cmd <= '{addr: job.base, wdata: job.wdata, write: job.write};
    end
    else if (state == M_NEXT)
    begin
      mem_cmd.addr <= {job_q.base[`ADDR_BITS-1:1], cnt + 1'b1};  // upper word of the block
    end
    if (state == M_REQ && mem_ack)
    begin
      done_data[cnt] <= mem_rdata;  // first edge with ack high
    end
  end

  always_comb
  begin
    for (int k = 0; k < `BLOCK_WORDS; k++)
    begin
      done.word[k].we   = done_we[k];
      done.word[k].idx  = {job_q.base[`CACHE_IDX_BITS-1:1], 1'(k)};
      done.word[k].data = done_data[k];
    end
  end

  a_cmd_stable: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_req && !mem_ack |=> $stable(mem_cmd))
    else $error("mem_cmd changed while waiting for mem_ack");

endmodule

// ==== source/snowball_cache.sv ====
// CPU side of the snowball cache: translation, tag compare, refill and write-through control
`timescale 1ns/1ns
`include "cache_settings.svh"

module snowball_cache import cache_pkg::*;
(
  input  logic       CPU_CLK,
  input  logic       RST,
  input  logic       vmem_on,
  input  logic       cpu_req,
  input  cpu_req_t   cpu_cmd,
  output logic       cpu_ack,
  output cpu_rsp_t   cpu_rsp,
  output line_idx_t  line_raddr,
  output line_idx_t  line_waddr,
  output logic       data_we,
  output word_t      data_wdata,
  input  word_t      data_rdata,
  output logic       tag_we,
  output cache_tag_t tag_wdata,
  input  cache_tag_t tag_rdata,
  output tlb_idx_t   tlb_raddr,
  output logic       tlb_we,
  output tlb_idx_t   tlb_waddr,
  output tlb_entry_t tlb_wdata,
  input  tlb_entry_t tlb_rdata,
  output logic       job_req,
  output mem_job_t   job,
  input  logic       job_ack,
  input  mem_done_t  done
);

  cache_state_t             state;
  cpu_req_t                 req_q;
  page_t                    ppage_q;
  logic                     fault_q;
  cache_tag_t               tag_q;
  word_t                    word_q;
  logic                     from_mem_q;    // request went out to memory
  logic [`CACHE_LINES-1:0]  valid;

  page_t                    req_vpage;
  tlb_idx_t                 req_tidx;
  line_idx_t                req_line;
  addr_t                    paddr;
  logic                     hit;
  logic                     read_hit;
  logic                     go_mem;
  logic                     refill_now;
  refill_word_t             refill;

  // arrays are read with the address of the request being sampled
  assign line_raddr = cpu_cmd.addr[`CACHE_IDX_BITS-1:0];
  assign tlb_raddr  = cpu_cmd.addr[`CACHE_IDX_BITS +: `TLB_IDX_BITS];

  assign req_vpage = req_q.addr[`ADDR_BITS-1 -: `PAGE_BITS];
  assign req_tidx  = req_q.addr[`CACHE_IDX_BITS +: `TLB_IDX_BITS];
  assign req_line  = req_q.addr[`CACHE_IDX_BITS-1:0];
  assign paddr     = {ppage_q, req_q.addr[`ADDR_BITS-`PAGE_BITS-1:0]};

  assign hit      = valid[req_line] && (tag_q == {ppage_q, req_tidx});
  assign read_hit = hit && !req_q.write && !req_q.inhibit;
  assign go_mem   = !req_q.tlb_load && !fault_q && !read_hit;

  // refill lands one word per cycle, word 0 with job_ack, word 1 in ACK
  assign refill     = done.word[state == ACK];
  assign refill_now = from_mem_q && ((state == ACK) || (state == WAIT_MEM && job_ack));

  // --------------------------------------------------
  // request FSM
  // --------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state   <= IDLE;
      cpu_ack <= 1'b0;
      job_req <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
          if (cpu_req)
          begin
            state <= LOOKUP;
          end
        LOOKUP:
          state <= DECIDE;
        DECIDE:
          if (go_mem)
          begin
            job_req <= 1'b1;
            state   <= WAIT_MEM;
          end
          else
          begin
            state <= ACK;
          end
        WAIT_MEM:
          if (job_ack)
          begin
            job_req <= 1'b0;
            state   <= ACK;
          end
        ACK:
        begin
          cpu_ack <= 1'b1;
          state   <= RELEASE;
        end
        RELEASE:
          if (!cpu_req)
          begin
            cpu_ack <= 1'b0;
            state   <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid <= '0;
    end
    else if (tag_we)
    begin
      valid[line_waddr] <= 1'b1;
    end
  end

  // --------------------------------------------------
  // request, lookup and response registers
  // --------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    case (state)
      IDLE:
        if (cpu_req)
        begin
          req_q <= cpu_cmd;
        end
      LOOKUP:
      begin
        ppage_q <= vmem_on ? tlb_rdata.ppage : req_vpage;
        fault_q <= vmem_on && !req_q.tlb_load && (tlb_rdata.vtag != req_vpage);
        tag_q   <= tag_rdata;
        word_q  <= data_rdata;
      end
      DECIDE:
      begin
        from_mem_q    <= go_mem;
        cpu_rsp.fault <= fault_q;
        cpu_rsp.rdata <= read_hit ? word_q : '0;
        job.wdata     <= req_q.wdata;
        job.write     <= req_q.write;
        job.single    <= req_q.write || req_q.inhibit;
        job.base      <= (req_q.write || req_q.inhibit) ? paddr
                                                        : {paddr[`ADDR_BITS-1:1], 1'b0};
      end
      ACK:
        if (from_mem_q && !req_q.write)
        begin
          cpu_rsp.rdata <= req_q.inhibit ? done.word[0].data : done.word[req_q.addr[0]].data;
        end
      default:
      begin
      end
    endcase
  end

  // --------------------------------------------------
  // array write ports
  // --------------------------------------------------
  always_comb
  begin
    data_we    = 1'b0;
    tag_we     = 1'b0;
    line_waddr = req_line;
    data_wdata = req_q.wdata;
    tag_wdata  = {ppage_q, req_tidx};  // same tag for both block words
    if (state == DECIDE)
    begin
      data_we = go_mem && req_q.write && hit;  // write hit, through to memory as well
    end
    else if (refill_now)
    begin
      data_we    = refill.we;
      tag_we     = refill.we;
      line_waddr = refill.idx;
      data_wdata = refill.data;
    end
  end

  assign tlb_we    = (state == DECIDE) && req_q.tlb_load;
  assign tlb_waddr = req_tidx;
  assign tlb_wdata = tlb_entry_t'(req_q.wdata);

  a_ack_needs_req: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(cpu_ack) |-> $past(cpu_req))
    else $error("cpu_ack raised with no pending request");

  a_job_req_clean: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(job_req) |-> !$past(job_ack))
    else $error("job_req raised while job_ack still high");

endmodule

// ==== source/snowball_top.sv ====
// top level of the snowball cache, joins the controller, the three arrays and the memory port
`timescale 1ns/1ns
`include "cache_settings.svh"

module snowball_top import cache_pkg::*;
(
  input  logic     CPU_CLK,
  input  logic     RST,
  input  logic     vmem_on,
  input  logic     cpu_req,
  input  cpu_req_t cpu_cmd,
  output logic     cpu_ack,
  output cpu_rsp_t cpu_rsp,
  output logic     mem_req,
  output mem_cmd_t mem_cmd,
  input  logic     mem_ack,
  input  word_t    mem_rdata
);

  line_idx_t  line_raddr, line_waddr;
  logic       data_we, tag_we, tlb_we;
  word_t      data_wdata, data_rdata;
  cache_tag_t tag_wdata, tag_rdata;
  tlb_idx_t   tlb_raddr, tlb_waddr;
  tlb_entry_t tlb_wdata, tlb_rdata;
  logic       job_req, job_ack;
  mem_job_t   job;
  mem_done_t  done;

  snowball_cache snowball_cache_i (.CPU_CLK, .RST, .vmem_on, .cpu_req, .cpu_cmd, .cpu_ack,
    .cpu_rsp, .line_raddr, .line_waddr, .data_we, .data_wdata, .data_rdata, .tag_we,
    .tag_wdata, .tag_rdata, .tlb_raddr, .tlb_we, .tlb_waddr, .tlb_wdata, .tlb_rdata,
    .job_req, .job, .job_ack, .done);

  mem_port_fsm mem_port_fsm_i (.CPU_CLK, .RST, .job_req, .job, .job_ack, .done, .mem_req,
    .mem_cmd, .mem_ack, .mem_rdata);

  dual_port_ram #(.WIDTH(`WORD_BITS), .DEPTH(`CACHE_LINES)) cache_data (.CPU_CLK,
    .we(data_we), .waddr(line_waddr), .wdata(data_wdata), .raddr(line_raddr),
    .rdata(data_rdata));

  dual_port_ram #(.WIDTH(`CACHE_TAG_BITS), .DEPTH(`CACHE_LINES)) cache_tag (.CPU_CLK,
    .we(tag_we), .waddr(line_waddr), .wdata(tag_wdata), .raddr(line_raddr),
    .rdata(tag_rdata));

  dual_port_ram #(.WIDTH($bits(tlb_entry_t)), .DEPTH(`TLB_ENTRIES)) tlb_ram (.CPU_CLK,
    .we(tlb_we), .waddr(tlb_waddr), .wdata(tlb_wdata), .raddr(tlb_raddr),
    .rdata(tlb_rdata));

endmodule

// ==== tests/mem_model.sv ====
// behavioral memory for the snowball cache testbench, answers each word request after a random gap
`timescale 1ns/1ns

module mem_model import cache_pkg::*;
#(
  parameter int MAX_GAP     = 4,   // longest ack delay in cycles
  parameter int DRIVE_DELAY = 10
)
(
  input  logic     CPU_CLK,
  input  logic     mem_req,
  input  mem_cmd_t mem_cmd,
  output logic     mem_ack,
  output word_t    mem_rdata,
  output int       rd_count,
  output int       wr_count,
  output addr_t    last_waddr,
  output word_t    last_wdata
);

  word_t store [addr_t];  // written words only

  // odd multiplier keeps every address distinct
  function automatic word_t initial_word(input addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A3C_96E1;
  endfunction

  task automatic serve(input mem_cmd_t c);
    if (c.write)
    begin
      store[c.addr] = c.wdata;
      last_waddr    = c.addr;
      last_wdata    = c.wdata;
      wr_count++;
    end
    else
    begin
      mem_rdata = store.exists(c.addr) ? store[c.addr] : initial_word(c.addr);
      rd_count++;
    end
    mem_ack = 1'b1;
  endtask

  // --------------------------------------------------
  // four-phase slave, one word per handshake
  // --------------------------------------------------
  initial
  begin
    int gap;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    rd_count   = 0;
    wr_count   = 0;
    last_waddr = '0;
    last_wdata = '0;
    forever
    begin
      @(posedge CPU_CLK);
      #DRIVE_DELAY;
      if (mem_req)
      begin
        gap = $urandom_range(MAX_GAP, 0);
        repeat (gap)
        begin
          @(posedge CPU_CLK);
          #DRIVE_DELAY;
        end
        serve(mem_cmd);  // mem_cmd held while mem_req high
        while (mem_req)
        begin
          @(posedge CPU_CLK);
          #DRIVE_DELAY;
        end
        mem_ack = 1'b0;
      end
    end
  end

endmodule

// ==== tests/snowball_tb.sv ====
// testbench for snowball_top that runs directed and random CPU requests against a reference model
`timescale 1ns/1ns
`include "cache_settings.svh"

module snowball_tb import cache_pkg::*;
();

  localparam int PERIOD        = 100;
  localparam int DRIVE_DELAY   = 10;
  localparam int RESET_CYCLES  = 8;
  localparam int MAX_GAP       = 5;
  localparam int DIRECTED_REQS = 19;
  localparam int RANDOM_REQS   = 60;
  localparam int WORST_CYCLES  = 8 + `BLOCK_WORDS * (MAX_GAP + 4);  // slowest refill
  localparam int REQ_LIMIT     = 2 * WORST_CYCLES;
  localparam int WATCHDOG_NS   =
    (RESET_CYCLES + (DIRECTED_REQS + RANDOM_REQS) * WORST_CYCLES * 2) * PERIOD;

  logic     CPU_CLK = 1'b0;
  logic     RST, vmem_on, cpu_req, cpu_ack, mem_req, mem_ack;
  cpu_req_t cpu_cmd;
  cpu_rsp_t cpu_rsp;
  mem_cmd_t mem_cmd;
  word_t    mem_rdata, last_wdata;
  addr_t    last_waddr;
  int       rd_count, wr_count;

  // reference model
  word_t                   ref_mem [addr_t];
  tlb_entry_t              tlb_ref [`TLB_ENTRIES];
  logic [`CACHE_LINES-1:0] line_valid;
  cache_tag_t              line_tag [`CACHE_LINES];
  word_t                   line_data [`CACHE_LINES];
  word_t                   exp_rdata, exp_wdata;
  addr_t                   exp_waddr;
  logic                    exp_fault, exp_fast, chk_data, chk_write;
  int                      exp_rd, exp_wr;

  always #(PERIOD/2) CPU_CLK = ~CPU_CLK;

  snowball_top snowball_top_i (.CPU_CLK, .RST, .vmem_on, .cpu_req, .cpu_cmd, .cpu_ack,
    .cpu_rsp, .mem_req, .mem_cmd, .mem_ack, .mem_rdata);

  mem_model #(.MAX_GAP(MAX_GAP), .DRIVE_DELAY(DRIVE_DELAY)) mem_model_i (.CPU_CLK, .mem_req,
    .mem_cmd, .mem_ack, .mem_rdata, .rd_count, .wr_count, .last_waddr, .last_wdata);

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic word_t expected_word(input addr_t a);
    if (ref_mem.exists(a))
    begin
      return ref_mem[a];
    end
    return (a * 32'h9E37_79B1) ^ 32'h5A3C_96E1;  // power-on fill of the memory
  endfunction

  // --------------------------------------------------
  // reference model stepped one request at a time
  // --------------------------------------------------
  task automatic predict(input cpu_req_t c);
    page_t      ppage;
    addr_t      pa;
    line_idx_t  line;
    tlb_idx_t   tidx;
    logic       hit;
    tidx      = c.addr[15:8];
    line      = c.addr[7:0];
    ppage     = vmem_on ? tlb_ref[tidx].ppage : c.addr[31:16];
    pa        = {ppage, c.addr[15:0]};
    hit       = line_valid[line] && (line_tag[line] == {ppage, tidx});
    chk_data  = 1'b0;
    chk_write = 1'b0;
    exp_fault = 1'b0;
    exp_fast  = 1'b1;
    if (c.tlb_load)
    begin
      tlb_ref[tidx] = tlb_entry_t'(c.wdata);
    end
    else if (vmem_on && (tlb_ref[tidx].vtag != c.addr[31:16]))
    begin
      exp_fault = 1'b1;
    end
    else if (c.write)
    begin
      exp_fast    = 1'b0;
      chk_write   = 1'b1;
      exp_waddr   = pa;
      exp_wdata   = c.wdata;
      ref_mem[pa] = c.wdata;
      exp_wr++;
      if (hit)
      begin
        line_data[line] = c.wdata;
      end
    end
    else if (c.inhibit || !hit)
    begin
      exp_fast  = 1'b0;
      chk_data  = 1'b1;
      exp_rdata = expected_word(pa);
      exp_rd    = exp_rd + (c.inhibit ? 1 : `BLOCK_WORDS);
      for (int k = 0; k < `BLOCK_WORDS && !c.inhibit; k++)
      begin
        line_valid[{line[7:1], k[0]}] = 1'b1;
        line_tag[{line[7:1], k[0]}]   = {ppage, tidx};
        line_data[{line[7:1], k[0]}]  = expected_word({pa[31:1], k[0]});
      end
    end
    else
    begin
      chk_data  = 1'b1;
      exp_rdata = line_data[line];
    end
  endtask

  // entered and left a drive delay after a clock edge
  task automatic run_request(input cpu_req_t c);
    int waited;
    waited = 0;
    predict(c);
    cpu_cmd = c;
    cpu_req = 1'b1;
    while (!cpu_ack)
    begin
      @(posedge CPU_CLK);
      #DRIVE_DELAY;
      waited++;
      if (waited > REQ_LIMIT)
      begin
        $display("no cpu_ack within %0d cycles for address %h", REQ_LIMIT, c.addr);
        abort_run();
      end
    end
    cpu_req = 1'b0;
    while (cpu_ack)
    begin
      @(posedge CPU_CLK);
      #DRIVE_DELAY;
    end
  endtask

  task automatic read_word(input addr_t a, input logic inhibit);
    run_request('{addr: a, wdata: '0, write: 1'b0, tlb_load: 1'b0, inhibit: inhibit});
  endtask

  task automatic write_word(input addr_t a, input word_t d);
    run_request('{addr: a, wdata: d, write: 1'b1, tlb_load: 1'b0, inhibit: 1'b0});
  endtask

  task automatic load_translation(input tlb_idx_t idx, input page_t pp, input page_t vt);
    run_request('{addr: {16'h0, idx, 8'h0}, wdata: {pp, vt}, write: 1'b0, tlb_load: 1'b1,
      inhibit: 1'b0});
  endtask

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_reset_quiet: assert property (@(posedge CPU_CLK) $rose(RST) |-> !cpu_ack && !mem_req)
    else
    begin
      $display("ERR %0t: cpu_ack or mem_req high after reset", $time);
      abort_run();
    end

  a_rsp_fault: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(cpu_ack) |-> cpu_rsp.fault == exp_fault)
    else
    begin
      $display("ERR %0t: fault %b, expected %b", $time, cpu_rsp.fault, exp_fault);
      abort_run();
    end

  a_rsp_data: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(cpu_ack) && chk_data |-> cpu_rsp.rdata == exp_rdata)
    else
    begin
      $display("ERR %0t: read data %h, expected %h", $time, cpu_rsp.rdata, exp_rdata);
      abort_run();
    end

  a_mem_counts: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(cpu_ack) |-> rd_count == exp_rd && wr_count == exp_wr)
    else
    begin
      $display("ERR %0t: %0d reads %0d writes, expected %0d and %0d", $time,
        rd_count, wr_count, exp_rd, exp_wr);
      abort_run();
    end

  a_write_through: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(cpu_ack) && chk_write |-> last_waddr == exp_waddr && last_wdata == exp_wdata)
    else
    begin
      $display("ERR %0t: memory write %h at %h, expected %h at %h", $time,
        last_wdata, last_waddr, exp_wdata, exp_waddr);
      abort_run();
    end

  a_hit_latency: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(cpu_req) && exp_fast |-> ##4 $rose(cpu_ack))
    else
    begin
      $display("ERR %0t: cpu_ack not 3 edges after the request", $time);
      abort_run();
    end

  a_fast_no_mem: assert property (@(posedge CPU_CLK) disable iff (!RST)
    cpu_req && exp_fast |-> !mem_req)
    else
    begin
      $display("ERR %0t: memory request on a hit, fault or tlb load", $time);
      abort_run();
    end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, a request never completed", WATCHDOG_NS);
    abort_run();
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial
  begin
    addr_t a;
    int    kind;
    void'($urandom(42));
    RST        = 1'b0;
    vmem_on    = 1'b0;
    cpu_req    = 1'b0;
    cpu_cmd    = '0;
    line_valid = '0;
    exp_fast   = 1'b0;
    chk_data   = 1'b0;
    chk_write  = 1'b0;
    exp_fault  = 1'b0;
    exp_rd     = 0;
    exp_wr     = 0;
    repeat (RESET_CYCLES) @(posedge CPU_CLK);
    #DRIVE_DELAY;
    RST = 1'b1;
    @(posedge CPU_CLK);
    #DRIVE_DELAY;
    read_word(32'h0012_3456, 1'b0);        // miss with a block refill
    read_word(32'h0012_3457, 1'b0);        // other word of the block hits
    write_word(32'h0012_3456, 32'hC0FF_EE01);
    read_word(32'h0012_3456, 1'b0);
    write_word(32'h0040_0811, 32'h1234_5678);
    read_word(32'h0040_0811, 1'b0);
    read_word(32'h0077_1230, 1'b1);
    read_word(32'h0077_1230, 1'b1);
    read_word(32'h0077_1230, 1'b0);        // still a miss after inhibited reads
    read_word(32'h0012_3456, 1'b1);
    vmem_on = 1'b1;
    load_translation(8'h34, 16'h00AB, 16'h0012);
    load_translation(8'h56, 16'h0300, 16'h0444);
    read_word(32'h0012_3400, 1'b0);
    read_word(32'h0012_3401, 1'b0);
    read_word(32'h0099_3410, 1'b0);        // virtual tag mismatch
    write_word(32'h0099_3404, 32'hDEAD_0004);
    write_word(32'h0012_3402, 32'h0BAD_F00D);
    read_word(32'h0012_3402, 1'b0);
    read_word(32'h0444_5620, 1'b0);
    vmem_on = 1'b0;
    for (int n = 0; n < RANDOM_REQS; n++)
    begin
      a    = {page_t'($urandom_range(3, 0)), tlb_idx_t'($urandom_range(1, 0)),
              line_idx_t'($urandom_range(15, 0))};
      kind = $urandom_range(9, 0);
      if (kind < 6)
      begin
        read_word(a, 1'b0);
      end
      else if (kind < 8)
      begin
        write_word(a, $urandom);
      end
      else
      begin
        read_word(a, 1'b1);
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/cache_pkg.sv
source/dual_port_ram.sv
source/mem_port_fsm.sv
source/snowball_cache.sv
source/snowball_top.sv
tests/mem_model.sv
tests/snowball_tb.sv
